/* src/arena_pkg.sv */
// Package with display timing, sprite, health and colour constants, typedefs and the state enum
package arena_pkg;

    typedef logic [10:0] coord_t;
    typedef logic [11:0] rgb_t;
    typedef logic [6:0]  hp_t;
    typedef logic [9:0]  rom_addr_t;

    typedef enum logic [1:0] {IDLE, FIGHT, DEFEATED} game_state_t;

    // ==============================
    // Reduced 320x240 raster timing
    // ==============================
    localparam coord_t H_ACTIVE = 11'd320;
    localparam coord_t H_FRONT  = 11'd8;
    localparam coord_t H_SYNC   = 11'd48;
    localparam coord_t H_BACK   = 11'd24;
    localparam coord_t H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam coord_t V_ACTIVE = 11'd240;
    localparam coord_t V_FRONT  = 11'd3;
    localparam coord_t V_SYNC   = 11'd4;
    localparam coord_t V_BACK   = 11'd15;
    localparam coord_t V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Sprite geometry and pipeline depths
    localparam coord_t SPRITE_SIZE = 11'd32;
    localparam coord_t SPRITE_HALF = 11'd16;
    localparam int     ROM_DEPTH   = 1024;
    localparam rgb_t   KEY_COLOR   = 12'hF00;
    localparam rgb_t   BG_COLOR    = 12'h003;
    localparam int     RENDER_LAT  = 4;
    localparam int     BAR_LAT     = 2;

    // Boss health and its bar
    localparam hp_t    BOSS_HP_MAX = 7'd64;
    localparam hp_t    HIT_DAMAGE  = 7'd5;
    localparam rgb_t   BAR_COLOR   = 12'h0F0;
    localparam rgb_t   BAR_EMPTY   = 12'h444;
    localparam coord_t BAR_TOP_OFS = 11'd6;
    localparam coord_t BAR_ROWS    = 11'd4;

endpackage

/* src/vga_timing.sv */
// Raster counters with sync and blanking generation for the reduced display
`timescale 1ns/1ns

module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output arena_pkg::coord_t hcount,
    output arena_pkg::coord_t vcount,
    output logic              hsync,
    output logic              vsync,
    output logic              hblnk,
    output logic              vblnk
);
    import arena_pkg::*;

    coord_t h_nxt;
    coord_t v_nxt;

    // Next position, vcount steps once per line
    always_comb begin
        if (hcount == H_TOTAL - 11'd1) begin
            h_nxt = '0;
            if (vcount == V_TOTAL - 11'd1) begin
                v_nxt = '0;
            end else begin
                v_nxt = vcount + 11'd1;
            end
        end else begin
            h_nxt = hcount + 11'd1;
            v_nxt = vcount;
        end
    end

    // Decoding the next count keeps sync and blanking aligned with the counts
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= h_nxt;
            vcount <= v_nxt;
            hblnk  <= (h_nxt >= H_ACTIVE);
            vblnk  <= (v_nxt >= V_ACTIVE);
            hsync  <= (h_nxt >= H_ACTIVE + H_FRONT) &&
                      (h_nxt <  H_ACTIVE + H_FRONT + H_SYNC);
            vsync  <= (v_nxt >= V_ACTIVE + V_FRONT) &&
                      (v_nxt <  V_ACTIVE + V_FRONT + V_SYNC);
        end
    end

endmodule

/* src/game_ctrl.sv */
// Fight state machine producing the fight level and the health reload pulse
`timescale 1ns/1ns

module game_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  arena_pkg::hp_t hp,
    output logic           fight,
    output logic           hp_load
);
    import arena_pkg::*;

    game_state_t state;
    game_state_t state_nxt;

    // ==============================
    // State register
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ==============================
    // Next state and outputs
    // ==============================
    always_comb begin
        state_nxt = state;
        hp_load   = 1'b0;
        case (state)
            IDLE, DEFEATED: begin
                if (start) begin
                    state_nxt = FIGHT;
                    // Health reloads on the same edge that enters FIGHT
                    hp_load   = 1'b1;
                end
            end
            FIGHT: begin
                // A start strobe has no effect here
                if (hp == '0) begin
                    state_nxt = DEFEATED;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    assign fight = (state == FIGHT);

endmodule

/* src/boss_health.sv */
// Boss hit point counter with reload and saturating damage
`timescale 1ns/1ns

module boss_health (
    input  logic           clk,
    input  logic           rst,
    input  logic           hp_load,
    input  logic           hit,
    input  logic           fight,
    output arena_pkg::hp_t hp
);
    import arena_pkg::*;

    hp_t hp_after_hit;

    // Damage never takes the count below zero
    always_comb begin
        if (hp > HIT_DAMAGE) begin
            hp_after_hit = hp - HIT_DAMAGE;
        end else begin
            hp_after_hit = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hp <= '0;
        end else if (hp_load) begin
            hp <= BOSS_HP_MAX;
        end else if (hit && fight) begin
            hp <= hp_after_hit;
        end
    end

endmodule

/* src/boss_rom.sv */
// Synchronous 32x32 boss sprite ROM built from the image rule
`timescale 1ns/1ns

module boss_rom (
    input  logic                 clk,
    input  arena_pkg::rom_addr_t rom_addr,
    output arena_pkg::rgb_t      rom_data
);
    import arena_pkg::*;

    rgb_t image [ROM_DEPTH];

    // Address is y*32+x, so x sits in the low five bits
    initial begin
        rom_addr_t  a;
        logic [4:0] px;
        logic [4:0] py;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            a  = rom_addr_t'(i);
            px = a[4:0];
            py = a[9:5];
            if (px < 5'd4 && py < 5'd4) begin
                image[i] = KEY_COLOR;
            end else begin
                // Blue fixed at 8 keeps every opaque pixel off the key
                image[i] = {px[4:1], py[4:1], 4'd8};
            end
        end
    end

    always_ff @(posedge clk) begin
        rom_data <= image[rom_addr];
    end

endmodule

/* src/boss_render.sv */
// Pipelined boss sprite overlay with window test, ROM addressing and colour key
`timescale 1ns/1ns

module boss_render (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fight,
    input  arena_pkg::hp_t       hp,
    input  arena_pkg::coord_t    boss_x,
    input  arena_pkg::coord_t    boss_y,
    input  arena_pkg::coord_t    hcount_in,
    input  arena_pkg::coord_t    vcount_in,
    input  logic                 hsync_in,
    input  logic                 vsync_in,
    input  logic                 hblnk_in,
    input  logic                 vblnk_in,
    output arena_pkg::rom_addr_t rom_addr,
    input  arena_pkg::rgb_t      rom_data,
    output arena_pkg::coord_t    hcount_out,
    output arena_pkg::coord_t    vcount_out,
    output logic                 hsync_out,
    output logic                 vsync_out,
    output logic                 hblnk_out,
    output logic                 vblnk_out,
    output arena_pkg::rgb_t      rgb,
    output logic                 boss_alive
);
    import arena_pkg::*;

    // Raster delay line, entry k is the raster seen by stage k+2
    coord_t hcount_d [RENDER_LAT];
    coord_t vcount_d [RENDER_LAT];
    logic   hsync_d  [RENDER_LAT];
    logic   vsync_d  [RENDER_LAT];
    logic   hblnk_d  [RENDER_LAT];
    logic   vblnk_d  [RENDER_LAT];

    logic       fight_r;
    hp_t        hp_r;
    coord_t     boss_x_r;
    coord_t     boss_y_r;
    coord_t     x_min;
    coord_t     y_min;
    coord_t     dx;
    coord_t     dy;
    coord_t     x_min_s2;
    coord_t     y_min_s2;
    logic       alive_s2;
    logic       win_s2;
    logic       alive_s3;
    logic       win_s3;
    logic [4:0] rel_x;
    logic [4:0] rel_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < RENDER_LAT; k++) begin
                hcount_d[k] <= '0;
                vcount_d[k] <= '0;
                hsync_d[k]  <= 1'b0;
                vsync_d[k]  <= 1'b0;
                hblnk_d[k]  <= 1'b0;
                vblnk_d[k]  <= 1'b0;
            end
        end else begin
            hcount_d[0] <= hcount_in;
            vcount_d[0] <= vcount_in;
            hsync_d[0]  <= hsync_in;
            vsync_d[0]  <= vsync_in;
            hblnk_d[0]  <= hblnk_in;
            vblnk_d[0]  <= vblnk_in;
            for (int k = 1; k < RENDER_LAT; k++) begin
                hcount_d[k] <= hcount_d[k-1];
                vcount_d[k] <= vcount_d[k-1];
                hsync_d[k]  <= hsync_d[k-1];
                vsync_d[k]  <= vsync_d[k-1];
                hblnk_d[k]  <= hblnk_d[k-1];
                vblnk_d[k]  <= vblnk_d[k-1];
            end
        end
    end

    // ==============================
    // Stage 1: input registers
    // ==============================
    always_ff @(posedge clk) begin
        boss_x_r <= boss_x;
        boss_y_r <= boss_y;
        if (rst) begin
            fight_r <= 1'b0;
            hp_r    <= '0;
        end else begin
            fight_r <= fight;
            hp_r    <= hp;
        end
    end

    // ==============================
    // Stage 2: alive flag and window
    // ==============================
    // Offsets wrap modulo 2048, so one unsigned compare covers both edges
    always_comb begin
        x_min = boss_x_r - SPRITE_HALF;
        y_min = boss_y_r - SPRITE_HALF;
        dx    = hcount_d[0] - x_min;
        dy    = vcount_d[0] - y_min;
    end

    always_ff @(posedge clk) begin
        x_min_s2 <= x_min;
        y_min_s2 <= y_min;
        if (rst) begin
            alive_s2 <= 1'b0;
            win_s2   <= 1'b0;
        end else begin
            alive_s2 <= fight_r && (hp_r != '0);
            win_s2   <= fight_r && (hp_r != '0) && !hblnk_d[0] && !vblnk_d[0] &&
                        (dx < SPRITE_SIZE) && (dy < SPRITE_SIZE);
        end
    end

    // ==============================
    // Stage 3: ROM address
    // ==============================
    assign rel_x    = 5'(hcount_d[1] - x_min_s2);
    assign rel_y    = 5'(vcount_d[1] - y_min_s2);
    assign rom_addr = {rel_y, rel_x};

    always_ff @(posedge clk) begin
        if (rst) begin
            alive_s3 <= 1'b0;
            win_s3   <= 1'b0;
        end else begin
            alive_s3 <= alive_s2;
            win_s3   <= win_s2;
        end
    end

    // Stage 4: colour select, rom_data lines up with the stage 3 flags
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb        <= '0;
            boss_alive <= 1'b0;
        end else begin
            boss_alive <= alive_s3;
            if (hblnk_d[2] || vblnk_d[2]) begin
                rgb <= '0;
            end else if (win_s3 && rom_data != KEY_COLOR) begin
                rgb <= rom_data;
            end else begin
                rgb <= BG_COLOR;
            end
        end
    end

    assign hcount_out = hcount_d[RENDER_LAT-1];
    assign vcount_out = vcount_d[RENDER_LAT-1];
    assign hsync_out  = hsync_d[RENDER_LAT-1];
    assign vsync_out  = vsync_d[RENDER_LAT-1];
    assign hblnk_out  = hblnk_d[RENDER_LAT-1];
    assign vblnk_out  = vblnk_d[RENDER_LAT-1];

endmodule

/* src/hp_bar_render.sv */
// Pipelined health bar overlay drawn above the boss sprite
`timescale 1ns/1ns

module hp_bar_render (
    input  logic              clk,
    input  logic              rst,
    input  arena_pkg::hp_t    hp,
    input  logic              boss_alive,
    input  arena_pkg::coord_t boss_x,
    input  arena_pkg::coord_t boss_y,
    input  arena_pkg::coord_t hcount_in,
    input  arena_pkg::coord_t vcount_in,
    input  logic              hsync_in,
    input  logic              vsync_in,
    input  logic              hblnk_in,
    input  logic              vblnk_in,
    input  arena_pkg::rgb_t   rgb_in,
    output arena_pkg::coord_t hcount_out,
    output arena_pkg::coord_t vcount_out,
    output logic              hsync_out,
    output logic              vsync_out,
    output logic              hblnk_out,
    output logic              vblnk_out,
    output arena_pkg::rgb_t   rgb
);
    import arena_pkg::*;

    coord_t hcount_d [BAR_LAT];
    coord_t vcount_d [BAR_LAT];
    logic   hsync_d  [BAR_LAT];
    logic   vsync_d  [BAR_LAT];
    logic   hblnk_d  [BAR_LAT];
    logic   vblnk_d  [BAR_LAT];

    coord_t col;
    coord_t row;
    logic   in_bar;
    logic   bar_s1;
    logic   full_s1;
    rgb_t   rgb_s1;

    // Bar is twice the sprite width, starting one sprite width left of centre
    always_comb begin
        col    = hcount_in - (boss_x - SPRITE_SIZE);
        row    = vcount_in - (boss_y - SPRITE_HALF - BAR_TOP_OFS);
        in_bar = boss_alive && !hblnk_in && !vblnk_in &&
                 (row < BAR_ROWS) && (col < SPRITE_SIZE + SPRITE_SIZE);
    end

    // Stage 1 decides, stage 2 muxes
    always_ff @(posedge clk) begin
        full_s1 <= (col < coord_t'(hp));
        rgb_s1  <= rgb_in;
        if (rst) begin
            bar_s1 <= 1'b0;
            rgb    <= '0;
        end else begin
            bar_s1 <= in_bar;
            if (bar_s1) begin
                rgb <= full_s1 ? BAR_COLOR : BAR_EMPTY;
            end else begin
                rgb <= rgb_s1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < BAR_LAT; k++) begin
                hcount_d[k] <= '0;
                vcount_d[k] <= '0;
                hsync_d[k]  <= 1'b0;
                vsync_d[k]  <= 1'b0;
                hblnk_d[k]  <= 1'b0;
                vblnk_d[k]  <= 1'b0;
            end
        end else begin
            hcount_d[0] <= hcount_in;
            vcount_d[0] <= vcount_in;
            hsync_d[0]  <= hsync_in;
            vsync_d[0]  <= vsync_in;
            hblnk_d[0]  <= hblnk_in;
            vblnk_d[0]  <= vblnk_in;
            for (int k = 1; k < BAR_LAT; k++) begin
                hcount_d[k] <= hcount_d[k-1];
                vcount_d[k] <= vcount_d[k-1];
                hsync_d[k]  <= hsync_d[k-1];
                vsync_d[k]  <= vsync_d[k-1];
                hblnk_d[k]  <= hblnk_d[k-1];
                vblnk_d[k]  <= vblnk_d[k-1];
            end
        end
    end

    assign hcount_out = hcount_d[BAR_LAT-1];
    assign vcount_out = vcount_d[BAR_LAT-1];
    assign hsync_out  = hsync_d[BAR_LAT-1];
    assign vsync_out  = vsync_d[BAR_LAT-1];
    assign hblnk_out  = hblnk_d[BAR_LAT-1];
    assign vblnk_out  = vblnk_d[BAR_LAT-1];

endmodule

/* src/boss_arena_top.sv */
// Top level joining raster timing, fight control, health, sprite ROM and both renderers
`timescale 1ns/1ns

module boss_arena_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              hit,
    input  arena_pkg::coord_t boss_x,
    input  arena_pkg::coord_t boss_y,
    output arena_pkg::coord_t hcount,
    output arena_pkg::coord_t vcount,
    output logic              hsync,
    output logic              vsync,
    output logic              hblnk,
    output logic              vblnk,
    output arena_pkg::rgb_t   rgb,
    output logic              boss_alive,
    output arena_pkg::hp_t    hp
);
    import arena_pkg::*;

    // Raster straight from the counters
    coord_t t_hcount;
    coord_t t_vcount;
    logic   t_hsync;
    logic   t_vsync;
    logic   t_hblnk;
    logic   t_vblnk;

    // Raster and colour after the sprite stage
    coord_t r_hcount;
    coord_t r_vcount;
    logic   r_hsync;
    logic   r_vsync;
    logic   r_hblnk;
    logic   r_vblnk;
    rgb_t   r_rgb;

    logic      fight;
    logic      hp_load;
    rom_addr_t rom_addr;
    rgb_t      rom_data;

    vga_timing vga_timing_i (
        .clk(clk), .rst(rst),
        .hcount(t_hcount), .vcount(t_vcount),
        .hsync(t_hsync), .vsync(t_vsync), .hblnk(t_hblnk), .vblnk(t_vblnk)
    );

    game_ctrl game_ctrl_i (
        .clk(clk), .rst(rst), .start(start), .hp(hp), .fight(fight), .hp_load(hp_load)
    );

    boss_health boss_health_i (
        .clk(clk), .rst(rst), .hp_load(hp_load), .hit(hit), .fight(fight), .hp(hp)
    );

    boss_rom boss_rom_i (
        .clk(clk), .rom_addr(rom_addr), .rom_data(rom_data)
    );

    boss_render boss_render_i (
        .clk(clk), .rst(rst), .fight(fight), .hp(hp), .boss_x(boss_x), .boss_y(boss_y),
        .hcount_in(t_hcount), .vcount_in(t_vcount), .hsync_in(t_hsync),
        .vsync_in(t_vsync), .hblnk_in(t_hblnk), .vblnk_in(t_vblnk),
        .rom_addr(rom_addr), .rom_data(rom_data),
        .hcount_out(r_hcount), .vcount_out(r_vcount), .hsync_out(r_hsync),
        .vsync_out(r_vsync), .hblnk_out(r_hblnk), .vblnk_out(r_vblnk),
        .rgb(r_rgb), .boss_alive(boss_alive)
    );

    hp_bar_render hp_bar_render_i (
        .clk(clk), .rst(rst), .hp(hp), .boss_alive(boss_alive),
        .boss_x(boss_x), .boss_y(boss_y),
        .hcount_in(r_hcount), .vcount_in(r_vcount), .hsync_in(r_hsync),
        .vsync_in(r_vsync), .hblnk_in(r_hblnk), .vblnk_in(r_vblnk), .rgb_in(r_rgb),
        .hcount_out(hcount), .vcount_out(vcount), .hsync_out(hsync),
        .vsync_out(vsync), .hblnk_out(hblnk), .vblnk_out(vblnk), .rgb(rgb)
    );

endmodule

/* bench/arena_asserts.sv */
// Bound assertions on sync, blanking, health range and boss visibility
`timescale 1ns/1ns

module arena_asserts (
    input logic            clk,
    input logic            rst,
    input logic            hsync,
    input logic            vsync,
    input logic            hblnk,
    input logic            vblnk,
    input arena_pkg::rgb_t rgb,
    input arena_pkg::hp_t  hp,
    input logic            boss_alive
);
    import arena_pkg::*;

    int assert_errs = 0;

    hsync_in_blank: assert property (@(posedge clk) disable iff (rst) hsync |-> hblnk)
        else begin
            $error("hsync high outside horizontal blanking");
            assert_errs++;
        end

    vsync_in_blank: assert property (@(posedge clk) disable iff (rst) vsync |-> vblnk)
        else begin
            $error("vsync high outside vertical blanking");
            assert_errs++;
        end

    black_in_blank: assert property (@(posedge clk) disable iff (rst)
                                     (hblnk || vblnk) |-> (rgb == '0))
        else begin
            $error("nonzero colour during blanking");
            assert_errs++;
        end

    hp_in_range: assert property (@(posedge clk) disable iff (rst) hp <= BOSS_HP_MAX)
        else begin
            $error("hit points above the maximum");
            assert_errs++;
        end

    // boss_alive trails hp by the four renderer stages
    alive_has_hp: assert property (@(posedge clk) disable iff (rst)
                                   boss_alive |-> ($past(hp, 4) != '0))
        else begin
            $error("boss_alive high with no hit points");
            assert_errs++;
        end

endmodule

bind boss_arena_top arena_asserts arena_asserts_i (
    .clk(clk), .rst(rst), .hsync(hsync), .vsync(vsync), .hblnk(hblnk), .vblnk(vblnk),
    .rgb(rgb), .hp(hp), .boss_alive(boss_alive)
);

/* bench/arena_checker.sv */
// Probe checker that samples DUT pixels and hit points and compares them with expected values
`timescale 1ns/1ns

module arena_checker (
    input  logic              clk,
    input  logic              rst,
    input  arena_pkg::coord_t hcount,
    input  arena_pkg::coord_t vcount,
    input  arena_pkg::rgb_t   rgb,
    input  arena_pkg::hp_t    hp,
    input  logic              boss_alive,
    input  logic              probe_req,
    input  int                test_num,
    input  arena_pkg::coord_t probe_h,
    input  arena_pkg::coord_t probe_v,
    input  arena_pkg::rgb_t   exp_rgb,
    input  arena_pkg::hp_t    exp_hp,
    output logic              probe_done,
    output int                pass_count,
    output int                fail_count
);
    import arena_pkg::*;

    logic hit_probe;
    logic exp_alive;

    // Output raster and rgb leave the DUT on the same cycle
    assign hit_probe = probe_req && !probe_done && (hcount == probe_h) && (vcount == probe_v);

    // Hit points only come back through a start, which also opens the fight,
    // and the fight only ends once they run out
    assign exp_alive = (exp_hp != '0);

    always @(posedge clk) begin
        if (rst) begin
            probe_done <= 1'b0;
            pass_count <= 0;
            fail_count <= 0;
        end else if (!probe_req) begin
            probe_done <= 1'b0;
        end else if (hit_probe) begin
            probe_done <= 1'b1;
            if (rgb === exp_rgb && hp === exp_hp && boss_alive === exp_alive) begin
                $display("PASS test %0d probe (%0d,%0d) rgb %h hp %0d alive %0b",
                         test_num, probe_h, probe_v, rgb, hp, boss_alive);
                pass_count <= pass_count + 1;
            end else begin
                $display("ERR at %0t: test %0d probe (%0d,%0d) expected %s, got %s",
                         $time, test_num, probe_h, probe_v,
                         $sformatf("rgb %h hp %0d alive %0b", exp_rgb, exp_hp, exp_alive),
                         $sformatf("rgb %h hp %0d alive %0b", rgb, hp, boss_alive));
                fail_count <= fail_count + 1;
            end
        end
    end

endmodule

/* bench/boss_arena_tb.sv */
// Testbench top with clock, reset, tests file reader, falling-edge stimulus and timeout
`timescale 1ns/1ns

module boss_arena_tb;
    import arena_pkg::*;

    localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);

    logic   clk;
    logic   rst;
    logic   start;
    logic   hit;
    coord_t boss_x;
    coord_t boss_y;
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;
    logic   boss_alive;
    hp_t    hp;

    // Probe handed to the checker
    logic   probe_req;
    int     test_num;
    coord_t probe_h;
    coord_t probe_v;
    rgb_t   exp_rgb;
    hp_t    exp_hp;
    logic   probe_done;
    int     pass_count;
    int     fail_count;

    // One entry per line of the tests file
    int     q_start [$];
    int     q_hits  [$];
    coord_t q_bx    [$];
    coord_t q_by    [$];
    coord_t q_ph    [$];
    coord_t q_pv    [$];
    rgb_t   q_rgb   [$];
    hp_t    q_hp    [$];

    logic   file_ok;
    int     cycles;
    int     cycle_limit = 1000;

    boss_arena_top boss_arena_top_i (
        .clk(clk), .rst(rst), .start(start), .hit(hit), .boss_x(boss_x), .boss_y(boss_y),
        .hcount(hcount), .vcount(vcount), .hsync(hsync), .vsync(vsync),
        .hblnk(hblnk), .vblnk(vblnk), .rgb(rgb), .boss_alive(boss_alive), .hp(hp)
    );

    arena_checker arena_checker_i (
        .clk(clk), .rst(rst), .hcount(hcount), .vcount(vcount), .rgb(rgb), .hp(hp),
        .boss_alive(boss_alive),
        .probe_req(probe_req), .test_num(test_num), .probe_h(probe_h), .probe_v(probe_v),
        .exp_rgb(exp_rgb), .exp_hp(exp_hp), .probe_done(probe_done),
        .pass_count(pass_count), .fail_count(fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==============================
    // Tests file and stepping
    // ==============================
    task automatic read_tests();
        int          fd;
        int          n;
        string       line;
        int          f_start;
        int          f_hits;
        int          f_bx;
        int          f_by;
        int          f_ph;
        int          f_pv;
        int unsigned f_rgb;
        int          f_hp;
        fd = $fopen("bench/arena_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file bench/arena_tests.txt");
            file_ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Lines starting with # describe the columns
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d %h %d",
                            f_start, f_hits, f_bx, f_by, f_ph, f_pv, f_rgb, f_hp);
                if (n == 8) begin
                    q_start.push_back(f_start);
                    q_hits.push_back(f_hits);
                    q_bx.push_back(coord_t'(f_bx));
                    q_by.push_back(coord_t'(f_by));
                    q_ph.push_back(coord_t'(f_ph));
                    q_pv.push_back(coord_t'(f_pv));
                    q_rgb.push_back(rgb_t'(f_rgb));
                    q_hp.push_back(hp_t'(f_hp));
                end
            end
        end
        $fclose(fd);
        if (q_start.size() == 0) begin
            $display("The tests file holds no usable test lines");
            file_ok = 1'b0;
        end
    endtask

    task automatic wait_for_row(input coord_t row);
        while (vcount != row) begin
            @(negedge clk);
        end
    endtask

    // Each test spans less than two frames
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles waiting for a probe", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        hit       = 1'b0;
        boss_x    = 11'd160;
        boss_y    = 11'd120;
        probe_req = 1'b0;
        test_num  = 0;
        probe_h   = '0;
        probe_v   = '0;
        exp_rgb   = '0;
        exp_hp    = '0;
        cycles    = 0;
        file_ok   = 1'b1;
        read_tests();
        cycle_limit = q_start.size() * 2 * FRAME_CYCLES + 1000;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < q_start.size(); i++) begin
            test_num = i + 1;
            if (q_start[i] != 0) begin
                start = 1'b1;
                @(negedge clk);
                start = 1'b0;
                @(negedge clk);
            end
            repeat (q_hits[i]) begin
                hit = 1'b1;
                @(negedge clk);
                hit = 1'b0;
                @(negedge clk);
            end
            // Position moves only in vertical blanking
            wait_for_row(V_ACTIVE);
            boss_x = q_bx[i];
            boss_y = q_by[i];
            wait_for_row('0);
            probe_h   = q_ph[i];
            probe_v   = q_pv[i];
            exp_rgb   = q_rgb[i];
            exp_hp    = q_hp[i];
            probe_req = 1'b1;
            while (!probe_done) begin
                @(negedge clk);
            end
            probe_req = 1'b0;
            @(negedge clk);
        end

        $display("Tests passed %0d, failed %0d, assertion failures %0d",
                 pass_count, fail_count, boss_arena_top_i.arena_asserts_i.assert_errs);
        if (file_ok && fail_count == 0 && boss_arena_top_i.arena_asserts_i.assert_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* build.f */
src/arena_pkg.sv
src/vga_timing.sv
src/game_ctrl.sv
src/boss_health.sv
src/boss_rom.sv
src/boss_render.sv
src/hp_bar_render.sv
src/boss_arena_top.sv
bench/arena_asserts.sv
bench/arena_checker.sv
bench/boss_arena_tb.sv

/* bench/arena_tests.txt */
# start hits boss_x boss_y probe_h probe_v exp_rgb exp_hp
# all decimal except exp_rgb, which is hex
0 0 160 120 160 120 003 0
0 0 160 120 330 100 000 0
1 0 160 120 170 125 DA8 64
0 0 160 120 145 105 003 64
0 0 160 120 148 104 208 64
0 0 160 120 175 135 FF8 64
0 3 160 120 176 98 0F0 49
0 0 160 120 177 98 444 49
0 0 100 80 110 85 DA8 49
0 0 100 80 170 125 003 49
0 0 100 80 78 58 0F0 49
0 10 100 80 110 85 003 0
0 2 100 80 78 58 003 0
1 12 100 80 110 85 DA8 4
0 1 100 80 110 85 003 0
